//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_issue
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
  input  logic [6:0]                opcode_i,
  input  logic [2:0]                funct3_i,
  input  logic                      alt_i,
  input  logic [core_pkg::XLEN-1:0] pc_i,
  input  logic [core_pkg::XLEN-1:0] op_a_i,
  input  logic [core_pkg::XLEN-1:0] op_b_i,
  input  logic [core_pkg::XLEN-1:0] imm_i,
  output logic [core_pkg::XLEN-1:0] result_o
);
  import core_pkg::*;

  logic [XLEN-1:0] b;
  logic [4:0]      shamt;
  logic [XLEN-1:0] sra_res;
  logic            is_sub;

  assign b       = (opcode_i == OP_R) ? op_b_i : imm_i;
  assign shamt   = b[4:0];
  assign sra_res = $signed(op_a_i) >>> shamt;
  assign is_sub  = opcode_i == OP_R && alt_i;  // addi has no sub form

  always_comb begin
    result_o = '0;
    case (opcode_i)
      OP_R, OP_IMM: begin
        case (funct3_i)
          FUNCT3_ADD: result_o = is_sub ? op_a_i - b : op_a_i + b;
          FUNCT3_SLL: result_o = op_a_i << shamt;
          FUNCT3_SLT: result_o = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(b)};
          FUNCT3_XOR: result_o = op_a_i ^ b;
          FUNCT3_SR:  result_o = alt_i ? sra_res : op_a_i >> shamt;
          FUNCT3_OR:  result_o = op_a_i | b;
          FUNCT3_AND: result_o = op_a_i & b;
          default:    result_o = '0;
        endcase
      end
      OP_AUIPC: result_o = pc_i + imm_i;
      OP_JAL:   result_o = pc_i + 32'd4;  // link only
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- build.f
core_pkg.sv
decode_stage.sv
imm_gen.sv
reg_file.sv
alu_unit.sv
mul_pipe.sv
writeback_reg.sv
issue_top.sv
tb_issue.sv

//--- core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_AW     = 5;
  localparam int NUM_REGS   = 32;
  localparam int MUL_STAGES = 5;  // ex1 is the decode register

  //////////////////////////////////////////////////
  // opcodes and function fields
  localparam logic [6:0] OP_R     = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_JAL   = 7'b1101111;

  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_SLL = 3'b001;
  localparam logic [2:0] FUNCT3_SLT = 3'b010;
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_SR  = 3'b101;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;

  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // sub, sra
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

  //////////////////////////////////////////////////
  // one instruction word, register and immediate views
  typedef union packed {
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r;
    struct packed {
      logic [11:0]       imm12;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } i;
  } instr_u;

endpackage

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic                                                  valid_i,
  input  logic [core_pkg::XLEN-1:0]                             instr_i,
  input  logic [core_pkg::XLEN-1:0]                             pc_i,
  input  logic [core_pkg::XLEN-1:0]                             rs1_data_i,
  input  logic [core_pkg::XLEN-1:0]                             rs2_data_i,
  input  logic [core_pkg::XLEN-1:0]                             imm_i,
  input  logic [core_pkg::MUL_STAGES-1:1]                       ex_valid_i,
  input  logic [core_pkg::MUL_STAGES-1:1][core_pkg::REG_AW-1:0] ex_rd_i,
  input  logic                                                  mul_wb_slot_i,
  input  logic [core_pkg::XLEN-1:0]                             ex5_result_i,
  input  logic                                                  wb_valid_i,
  input  logic [core_pkg::REG_AW-1:0]                           wb_rd_i,
  input  logic [core_pkg::XLEN-1:0]                             wb_data_i,
  output logic [core_pkg::REG_AW-1:0]                           rs1_o,
  output logic [core_pkg::REG_AW-1:0]                           rs2_o,
  output logic                                                  stall_o,
  output logic                                                  alu_valid_o,
  output logic                                                  ex_valid_o,
  output logic [core_pkg::REG_AW-1:0]                           rd_o,
  output logic [core_pkg::XLEN-1:0]                             pc_o,
  output logic [core_pkg::XLEN-1:0]                             op_a_o,
  output logic [core_pkg::XLEN-1:0]                             op_b_o,
  output logic [core_pkg::XLEN-1:0]                             imm_o,
  output logic [6:0]                                            opcode_o,
  output logic [2:0]                                            funct3_o,
  output logic                                                  alt_o
);
  import core_pkg::*;

  instr_u          ins;
  logic            is_mul;
  logic            is_alu;
  logic            reads_rs1;
  logic            reads_rs2;
  logic            raw_hazard;
  logic            accept;
  logic [XLEN-1:0] op_a_d;
  logic [XLEN-1:0] op_b_d;

  assign ins   = instr_i;
  assign rs1_o = ins.r.rs1;
  assign rs2_o = ins.r.rs2;

  assign is_mul = ins.r.opcode == OP_R && ins.r.funct7 == FUNCT7_MUL &&
                  ins.r.funct3 == FUNCT3_ADD;
  assign is_alu = (ins.r.opcode == OP_R && ins.r.funct7 != FUNCT7_MUL) ||
                  ins.r.opcode == OP_IMM || ins.r.opcode == OP_AUIPC ||
                  ins.r.opcode == OP_JAL;
  assign reads_rs1 = ins.r.opcode == OP_R || ins.r.opcode == OP_IMM;
  assign reads_rs2 = ins.r.opcode == OP_R;  // rs2 field is immediate on OP_IMM

  //////////////////////////////////////////////////
  // hazards against alu stage and ex1..ex4
  always_comb begin : hazard_check
    logic hit1;
    logic hit2;
    hit1 = 1'b0;
    hit2 = 1'b0;
    if ((alu_valid_o || ex_valid_o) && rd_o != '0) begin  // alu stage / ex1
      hit1 = rd_o == ins.r.rs1;
      hit2 = rd_o == ins.r.rs2;
    end
    for (int k = 1; k < MUL_STAGES - 1; k++) begin  // ex2..ex4
      if (ex_valid_i[k] && ex_rd_i[k] != '0) begin
        hit1 = hit1 | (ex_rd_i[k] == ins.r.rs1);
        hit2 = hit2 | (ex_rd_i[k] == ins.r.rs2);
      end
    end
    raw_hazard = (reads_rs1 && hit1) || (reads_rs2 && hit2);
  end

  // ex5 retires after writeback and takes priority
  always_comb begin : bypass_mux
    op_a_d = rs1_data_i;
    op_b_d = rs2_data_i;
    if (ex_valid_i[MUL_STAGES-1] && ex_rd_i[MUL_STAGES-1] == ins.r.rs1 && ins.r.rs1 != '0) begin
      op_a_d = ex5_result_i;
    end else if (wb_valid_i && wb_rd_i == ins.r.rs1) begin
      op_a_d = wb_data_i;
    end
    if (ex_valid_i[MUL_STAGES-1] && ex_rd_i[MUL_STAGES-1] == ins.r.rs2 && ins.r.rs2 != '0) begin
      op_b_d = ex5_result_i;
    end else if (wb_valid_i && wb_rd_i == ins.r.rs2) begin
      op_b_d = wb_data_i;
    end
  end

  assign stall_o = valid_i && ((is_alu && mul_wb_slot_i) || raw_hazard);
  assign accept  = valid_i && !stall_o;

  //////////////////////////////////////////////////
  // decode register
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alu_valid_o <= 1'b0;
      ex_valid_o  <= 1'b0;
    end else begin
      alu_valid_o <= accept && is_alu;  // bubble while stalled
      ex_valid_o  <= accept && is_mul;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_o     <= ins.r.rd;
    pc_o     <= pc_i;
    op_a_o   <= op_a_d;
    op_b_o   <= op_b_d;
    imm_o    <= imm_i;
    opcode_o <= ins.r.opcode;
    funct3_o <= ins.r.funct3;
    alt_o    <= ins.r.funct7 == FUNCT7_ALT;
  end

  a_one_path: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(alu_valid_o && ex_valid_o));

endmodule

`default_nettype wire

//--- imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
  input  logic [core_pkg::XLEN-1:0] instr_i,
  output logic [core_pkg::XLEN-1:0] imm_o
);
  import core_pkg::*;

  instr_u ins;

  assign ins = instr_i;

  always_comb begin
    case (ins.i.opcode)
      OP_IMM: begin
        imm_o = {{20{ins.i.imm12[11]}}, ins.i.imm12};
      end
      OP_AUIPC: begin  // upper 20 bits of the word
        imm_o = {ins.i.imm12, ins.i.rs1, ins.i.funct3, 12'b0};
      end
      OP_JAL: begin  // imm[20|10:1|11|19:12]
        imm_o = {{12{ins.i.imm12[11]}}, ins.i.rs1, ins.i.funct3,
                 ins.i.imm12[0], ins.i.imm12[10:1], 1'b0};
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- issue_top.sv
`timescale 1ns/1ns
`default_nettype none

module issue_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        valid_i,
  input  logic [core_pkg::XLEN-1:0]   instr_i,
  input  logic [core_pkg::XLEN-1:0]   pc_i,
  output logic                        stall_o,
  output logic                        wb_valid_o,
  output logic [core_pkg::REG_AW-1:0] wb_rd_o,
  output logic [core_pkg::XLEN-1:0]   wb_data_o
);
  import core_pkg::*;

  logic [REG_AW-1:0]                   rs1_addr;
  logic [REG_AW-1:0]                   rs2_addr;
  logic [XLEN-1:0]                     rs1_data;
  logic [XLEN-1:0]                     rs2_data;
  logic [XLEN-1:0]                     imm;
  logic                                alu_valid;
  logic                                ex_valid;
  logic [REG_AW-1:0]                   dec_rd;
  logic [XLEN-1:0]                     dec_pc;
  logic [XLEN-1:0]                     op_a;
  logic [XLEN-1:0]                     op_b;
  logic [XLEN-1:0]                     dec_imm;
  logic [6:0]                          opcode;
  logic [2:0]                          funct3;
  logic                                alt;
  logic [XLEN-1:0]                     alu_result;
  logic [MUL_STAGES-1:1]               stage_valid;
  logic [MUL_STAGES-1:1][REG_AW-1:0]   stage_rd;
  logic                                mul_wb_slot;
  logic [XLEN-1:0]                     ex5_result;

  decode_stage u_decode (
    .clk_i(clk_i), .rst_i(rst_i), .valid_i(valid_i), .instr_i(instr_i), .pc_i(pc_i),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm),
    .ex_valid_i(stage_valid), .ex_rd_i(stage_rd), .mul_wb_slot_i(mul_wb_slot),
    .ex5_result_i(ex5_result), .wb_valid_i(wb_valid_o), .wb_rd_i(wb_rd_o),
    .wb_data_i(wb_data_o), .rs1_o(rs1_addr), .rs2_o(rs2_addr), .stall_o(stall_o),
    .alu_valid_o(alu_valid), .ex_valid_o(ex_valid), .rd_o(dec_rd), .pc_o(dec_pc),
    .op_a_o(op_a), .op_b_o(op_b), .imm_o(dec_imm), .opcode_o(opcode),
    .funct3_o(funct3), .alt_o(alt)
  );

  imm_gen u_imm (.instr_i(instr_i), .imm_o(imm));

  reg_file u_rf (
    .clk_i(clk_i), .rst_i(rst_i), .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
    .we_i(wb_valid_o), .waddr_i(wb_rd_o), .wdata_i(wb_data_o),
    .rdata1_o(rs1_data), .rdata2_o(rs2_data)
  );

  alu_unit u_alu (
    .opcode_i(opcode), .funct3_i(funct3), .alt_i(alt), .pc_i(dec_pc),
    .op_a_i(op_a), .op_b_i(op_b), .imm_i(dec_imm), .result_o(alu_result)
  );

  mul_pipe u_mul (
    .clk_i(clk_i), .rst_i(rst_i), .ex1_valid_i(ex_valid), .ex1_rd_i(dec_rd),
    .op_a_i(op_a), .op_b_i(op_b), .stage_valid_o(stage_valid), .stage_rd_o(stage_rd),
    .mul_wb_slot_o(mul_wb_slot), .ex5_result_o(ex5_result)
  );

  writeback_reg u_wb (
    .clk_i(clk_i), .rst_i(rst_i), .alu_valid_i(alu_valid), .alu_rd_i(dec_rd),
    .alu_result_i(alu_result), .ex5_valid_i(stage_valid[MUL_STAGES-1]),
    .ex5_rd_i(stage_rd[MUL_STAGES-1]), .ex5_result_i(ex5_result),
    .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

endmodule

`default_nettype wire

//--- issue_vectors.txt
// number of programs, then per program: instruction count, (instruction, pc) pairs,
// then the expected final values of x1..x31
00000002
// program 1: ALU register and immediate ops, AUIPC, JAL, write to x0
00000010
12348093 00000100 FF900113 00000104
002081B3 00000108 40208233 0000010C
001122B3 00000110 40515333 00000114
00415393 00000118 0F00C413 0000011C
12345517 00000120 010005EF 00000124
00208033 00000128 00147633 0000012C
0065E6B3 00000130 00509733 00000134
FFA12793 00000138 40215813 0000013C
00000123 FFFFFFF9 0000011C 0000012A 00000001 FFFFFFFC 0FFFFFFF 000001D3
00000000 12345120 00000128 00000103 FFFFFFFC 00000246 00000001 FFFFFFFE
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000
// program 2: MULs in flight, MUL to ALU, ALU to MUL, MUL to MUL chains
0000000C
4D200093 00000200 FFD00113 00000204
022081B3 00000208 02108233 0000020C
022102B3 00000210 00118333 00000214
024303B3 00000218 0053C433 0000021C
028404B3 00000220 02208533 00000224
025505B3 00000228 02108033 0000022C
000004D2 FFFFFFFD FFFFF18A 00173C44 00000009 FFFFF65C 1FFF0070 1FFF0079
3F0E3931 FFFFF18A FFFF7DDA 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000

//--- mul_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module mul_pipe (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic                                                  ex1_valid_i,
  input  logic [core_pkg::REG_AW-1:0]                           ex1_rd_i,
  input  logic [core_pkg::XLEN-1:0]                             op_a_i,
  input  logic [core_pkg::XLEN-1:0]                             op_b_i,
  output logic [core_pkg::MUL_STAGES-1:1]                       stage_valid_o,
  output logic [core_pkg::MUL_STAGES-1:1][core_pkg::REG_AW-1:0] stage_rd_o,
  output logic                                                  mul_wb_slot_o,
  output logic [core_pkg::XLEN-1:0]                             ex5_result_o
);
  import core_pkg::*;

  logic [XLEN-1:0]   pp_ll_q2;
  logic [XLEN/2-1:0] pp_lh_q2;
  logic [XLEN/2-1:0] pp_hl_q2;
  logic [XLEN-1:0]   pp_ll_q3;
  logic [XLEN/2-1:0] cross_q3;
  logic [XLEN-1:0]   prod_q4;

  // index k carries stage ex(k+1)
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      stage_valid_o <= '0;
    end else begin
      stage_valid_o <= {stage_valid_o[MUL_STAGES-2:1], ex1_valid_i};
    end
  end

  always_ff @(posedge clk_i) begin
    stage_rd_o   <= {stage_rd_o[MUL_STAGES-2:1], ex1_rd_i};
    pp_ll_q2     <= op_a_i[XLEN/2-1:0] * op_b_i[XLEN/2-1:0];  // ex2 partial products
    pp_lh_q2     <= op_a_i[XLEN/2-1:0] * op_b_i[XLEN-1:XLEN/2];
    pp_hl_q2     <= op_a_i[XLEN-1:XLEN/2] * op_b_i[XLEN/2-1:0];
    pp_ll_q3     <= pp_ll_q2;  // ex3 cross sum
    cross_q3     <= pp_lh_q2 + pp_hl_q2;
    prod_q4      <= pp_ll_q3 + {cross_q3, {(XLEN/2){1'b0}}};  // ex4 final add
    ex5_result_o <= prod_q4;
  end

  assign mul_wb_slot_o = stage_valid_o[MUL_STAGES-2];  // ex4 owns wb two cycles out

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [core_pkg::REG_AW-1:0] raddr1_i,
  input  logic [core_pkg::REG_AW-1:0] raddr2_i,
  input  logic                        we_i,
  input  logic [core_pkg::REG_AW-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]   wdata_i,
  output logic [core_pkg::XLEN-1:0]   rdata1_o,
  output logic [core_pkg::XLEN-1:0]   rdata2_o
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // combinational read with same-cycle writes covered by the wb bypass
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_i)
    we_i |-> waddr_i != '0);

endmodule

`default_nettype wire

//--- tb_issue.sv
`timescale 1ns/1ns
`default_nettype none

module tb_issue;
  import core_pkg::*;

  localparam int VEC_DEPTH   = 256;
  localparam int FEED_LIMIT  = 400;
  localparam int DRAIN_LIMIT = 100;
  localparam int TAIL_CYCLES = MUL_STAGES + 1;  // longest result latency

  logic              clk_i;
  logic              rst_i;
  logic              valid_i;
  logic [XLEN-1:0]   instr_i;
  logic [XLEN-1:0]   pc_i;
  logic              stall_o;
  logic              wb_valid_o;
  logic [REG_AW-1:0] wb_rd_o;
  logic [XLEN-1:0]   wb_data_o;

  logic [XLEN-1:0] vec [VEC_DEPTH];
  logic [XLEN-1:0] shadow [NUM_REGS];  // architectural view built from writebacks
  int              wb_count;
  int              wb_expected;
  int              errors;
  int              n_pass;
  int              n_fail;
  int              seed;
  bit              timed_out;

  issue_top UUT (
    .clk_i(clk_i), .rst_i(rst_i), .valid_i(valid_i), .instr_i(instr_i), .pc_i(pc_i),
    .stall_o(stall_o), .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(negedge clk_i) begin
    if (rst_i && wb_valid_o) begin
      wb_count++;
      if (wb_rd_o == '0) begin
        $display("Mismatch at %0t: writeback with wb_rd_o of zero", $time);
        errors++;
      end
      shadow[wb_rd_o] = wb_data_o;
    end
  end

  //////////////////////////////////////////////////
  task apply_reset;
    @(posedge clk_i);
    rst_i   <= 1'b0;
    valid_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b1;
    @(negedge clk_i);
    if (wb_valid_o !== 1'b0) begin
      $display("Mismatch at %0t: wb_valid_o=%b after reset", $time, wb_valid_o);
      errors++;
    end
  endtask

  task clear_shadow;
    for (int r = 0; r < NUM_REGS; r++) begin
      shadow[r] = '0;
    end
    wb_count    = 0;
    wb_expected = 0;
  endtask

  // words are taken at the edge after a negedge that saw valid and no stall
  task feed_program(input int base, input int n, input bit gaps);
    int sent;
    int guard;
    bit take;
    bit first_checked;
    sent          = 0;
    guard         = 0;
    first_checked = 1'b0;
    while (sent < n) begin
      @(negedge clk_i);
      take = valid_i && !stall_o;
      if (valid_i && !first_checked) begin  // pipeline still empty
        first_checked = 1'b1;
        if (stall_o !== 1'b0) begin
          $display("Mismatch at %0t: stall_o=%b on the first word after reset",
                   $time, stall_o);
          errors++;
        end
      end
      if (take) begin
        sent++;
        if (instr_i[11:7] != '0) wb_expected++;  // rd field
      end
      guard++;
      if (guard > FEED_LIMIT) begin
        $display("timeout: instruction %0d was never accepted", sent);
        timed_out = 1'b1;
        return;
      end
      @(posedge clk_i);
      if (take || !valid_i) begin
        if (sent < n && !(gaps && ($random(seed) & 3) == 0)) begin
          valid_i <= 1'b1;
          instr_i <= vec[base + 2 * sent];
          pc_i    <= vec[base + 2 * sent + 1];
        end else begin
          valid_i <= 1'b0;  // idle or random gap
        end
      end
    end
  endtask

  task wait_drain;
    int guard;
    guard = 0;
    while (wb_count < wb_expected && !timed_out) begin
      @(posedge clk_i);
      guard++;
      if (guard > DRAIN_LIMIT) begin
        $display("timeout: only %0d of %0d results were written back", wb_count, wb_expected);
        timed_out = 1'b1;
      end
    end
    repeat (TAIL_CYCLES) @(posedge clk_i);  // catch stray writebacks
  endtask

  task compare_regs(input int exp_base);
    for (int r = 1; r < NUM_REGS; r++) begin
      if (shadow[r] !== vec[exp_base + r - 1]) begin
        $display("Mismatch at %0t: x%0d is %h, expected %h",
                 $time, r, shadow[r], vec[exp_base + r - 1]);
        errors++;
      end
    end
    if (wb_count != wb_expected) begin
      $display("Mismatch at %0t: %0d writebacks, expected %0d", $time, wb_count, wb_expected);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  initial begin
    int n_prog;
    int p;
    int n;
    int errs_before;
    int test_no;
    rst_i     = 1'b0;
    valid_i   = 1'b0;
    instr_i   = '0;
    pc_i      = '0;
    seed      = 32'h36727c39;
    errors    = 0;
    n_pass    = 0;
    n_fail    = 0;
    test_no   = 0;
    timed_out = 1'b0;
    clear_shadow();
    $readmemh("issue_vectors.txt", vec);
    n_prog = vec[0];
    if (n_prog <= 0) begin
      $display("no test programs were read from issue_vectors.txt");
      n_fail++;
    end
    // second pass repeats every program with random gaps in valid_i
    for (int g = 0; g < 2 && !timed_out; g++) begin
      p = 1;
      for (int t = 0; t < n_prog && !timed_out; t++) begin
        n           = vec[p];
        errs_before = errors;
        test_no++;
        apply_reset();
        clear_shadow();
        feed_program(p + 1, n, g[0]);
        if (!timed_out) wait_drain();
        if (!timed_out) compare_regs(p + 1 + 2 * n);
        if (!timed_out && errors == errs_before) begin
          $display("test %0d (program %0d, gaps %0d): ok", test_no, t + 1, g);
          n_pass++;
        end else begin
          $display("test %0d (program %0d, gaps %0d): failed", test_no, t + 1, g);
          n_fail++;
        end
        p = p + 1 + 2 * n + NUM_REGS - 1;
      end
    end
    $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- writeback_reg.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_reg (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        alu_valid_i,
  input  logic [core_pkg::REG_AW-1:0] alu_rd_i,
  input  logic [core_pkg::XLEN-1:0]   alu_result_i,
  input  logic                        ex5_valid_i,
  input  logic [core_pkg::REG_AW-1:0] ex5_rd_i,
  input  logic [core_pkg::XLEN-1:0]   ex5_result_i,
  output logic                        wb_valid_o,
  output logic [core_pkg::REG_AW-1:0] wb_rd_o,
  output logic [core_pkg::XLEN-1:0]   wb_data_o
);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_valid_o <= 1'b0;
    end else if (alu_valid_i) begin
      wb_valid_o <= alu_rd_i != '0;  // x0 target retires silently
    end else begin
      wb_valid_o <= ex5_valid_i && ex5_rd_i != '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_valid_i) begin
      wb_rd_o   <= alu_rd_i;
      wb_data_o <= alu_result_i;
    end else begin
      wb_rd_o   <= ex5_rd_i;
      wb_data_o <= ex5_result_i;
    end
  end

  // decode holds ALU ops off while ex4 is busy
  a_single_source: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(alu_valid_i && ex5_valid_i));

endmodule

`default_nettype wire
